// File: Makefile
# Verilator build and run of the ECC memory testbench
# Any variable can be set on the command line, e.g. make LOG=run.log

TOP       ?= eccMemTb
FILELIST  ?= eccMem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --timing
PASS_MSG  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass message
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/eccArray.sv
/* Codeword storage for the ECC memory
   One write port and one registered read port that returns the address along with the word */
module eccArray import hsiaoEccPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  eccWrReq_s            wr,
  input  logic                 rdEn,
  input  logic [AddrWidth-1:0] rdAddr,
  output eccRdRsp_s            rsp
);

  eccWord_u mem [Depth];

  // Read response registers
  logic                 rspValid;
  logic [AddrWidth-1:0] rspAddr;
  eccWord_u             rspWord;

  // Write completes at the edge
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.word;
    end
  end

  // A read in the same cycle as a write to that address sees the old word
  always_ff @(posedge clk) begin
    if (rdEn) begin
      rspAddr <= rdAddr;
      rspWord <= mem[rdAddr];
    end
  end

  // The response is valid for one cycle after each read request
  always_ff @(posedge clk) begin
    if (rst) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= rdEn;
    end
  end

  assign rsp = '{valid: rspValid, addr: rspAddr, word: rspWord};

endmodule

// File: design/eccMem.sv
/* ECC-protected memory of 64 words of 32 bits
   Hsiao SECDED with error injection on write and scrubbing on read */
module eccMem import hsiaoEccPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wrEn,
  input  logic [AddrWidth-1:0]  wrAddr,
  input  logic [DataWidth-1:0]  wrData,
  input  logic [TotalWidth-1:0] injMask,
  input  logic                  rdEn,
  input  logic [AddrWidth-1:0]  rdAddr,
  output logic                  rdValid,
  output logic [DataWidth-1:0]  rdData,
  output eccErr_s               rdErr,
  output logic [CountWidth-1:0] corrCount,
  output logic [CountWidth-1:0] uncorrCount
);

  eccWord_u  encWord;
  eccWrReq_s extWr;
  eccWrReq_s arrWr;
  eccRdRsp_s rsp;
  eccWord_u  corrWord;
  eccErr_s   corrErr;

  hsiaoEccEnc hsiaoEccEnc_i (
    .data    (wrData),
    .injMask (injMask),
    .word    (encWord)
  );

  // Bundle the encoded write for the arbiter
  assign extWr = '{en: wrEn, addr: wrAddr, word: encWord};

  eccArray eccArray_i (
    .clk    (clk),
    .rst    (rst),
    .wr     (arrWr),
    .rdEn   (rdEn),
    .rdAddr (rdAddr),
    .rsp    (rsp)
  );

  // The syndrome itself is not needed past the corrector
  hsiaoEccCor hsiaoEccCor_i (
    .in       (rsp.word),
    .out      (corrWord),
    .syndrome (),
    .err      (corrErr)
  );

  eccScrubber eccScrubber_i (
    .clk         (clk),
    .rst         (rst),
    .extWr       (extWr),
    .rsp         (rsp),
    .corrWord    (corrWord),
    .err         (corrErr),
    .arrWr       (arrWr),
    .rdValid     (rdValid),
    .rdData      (rdData),
    .rdErr       (rdErr),
    .corrCount   (corrCount),
    .uncorrCount (uncorrCount)
  );

endmodule

// File: design/eccScrubber.sv
/* Read result stage and write-back arbiter for the ECC memory
   Registers corrected reads, holds one pending scrub write and counts error events */
module eccScrubber import hsiaoEccPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  eccWrReq_s             extWr,
  input  eccRdRsp_s             rsp,
  input  eccWord_u              corrWord,
  input  eccErr_s               err,
  output eccWrReq_s             arrWr,
  output logic                  rdValid,
  output logic [DataWidth-1:0]  rdData,
  output eccErr_s               rdErr,
  output logic [CountWidth-1:0] corrCount,
  output logic [CountWidth-1:0] uncorrCount
);

  // One-entry holder for the pending write-back
  logic                 heldEn;
  logic [AddrWidth-1:0] heldAddr;
  eccWord_u             heldWord;

  // External write seen by the array on the previous edge
  logic                 lastExtEn;
  logic [AddrWidth-1:0] lastExtAddr;

  logic staleRsp;
  logic wbLoad;
  logic wbIssue;
  logic wbCancel;

  // Adds one unless the counter already sits at all ones
  function automatic logic [CountWidth-1:0] satInc(logic [CountWidth-1:0] count, logic hit);
    logic [CountWidth-1:0] next;
    next = count;
    if (hit && (count != '1)) begin
      next = count + 1'b1;
    end
    return next;
  endfunction

  // The response is stale if its address was written on the edge it was read,
  // or is being written now, so its repair must not overwrite newer data
  assign staleRsp = (lastExtEn && (lastExtAddr == rsp.addr)) ||
                    (extWr.en && (extWr.addr == rsp.addr));

  assign wbLoad   = rsp.valid && err.corrected && !staleRsp;
  assign wbIssue  = heldEn && !extWr.en;
  assign wbCancel = extWr.en && (extWr.addr == heldAddr);

  // External writes always win, the held entry goes out on an idle cycle
  always_comb begin
    if (extWr.en) begin
      arrWr = extWr;
    end else begin
      arrWr = '{en: heldEn, addr: heldAddr, word: heldWord};
    end
  end

  // A new correction replaces whatever is held
  always_ff @(posedge clk) begin
    if (rst) begin
      heldEn <= 1'b0;
    end else if (wbLoad) begin
      heldEn <= 1'b1;
    end else if (wbIssue || wbCancel) begin
      heldEn <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wbLoad) begin
      heldAddr <= rsp.addr;
      heldWord <= corrWord;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      lastExtEn <= 1'b0;
    end else begin
      lastExtEn <= extWr.en;
    end
  end

  always_ff @(posedge clk) begin
    lastExtAddr <= extWr.addr;
  end

  // Result stage, data and status are only meaningful with rdValid
  always_ff @(posedge clk) begin
    if (rst) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rsp.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp.valid) begin
      rdData <= corrWord.fields.data;
      rdErr  <= err;
    end
  end

  // Every checked read counts, including repeated hits on the same word
  always_ff @(posedge clk) begin
    if (rst) begin
      corrCount   <= '0;
      uncorrCount <= '0;
    end else begin
      corrCount   <= satInc(corrCount, rsp.valid && err.corrected);
      uncorrCount <= satInc(uncorrCount, rsp.valid && err.uncorrectable);
    end
  end

endmodule

// File: design/hsiaoEccCor.sv
/* Hsiao SECDED corrector
   Computes the syndrome, repairs a single flipped bit and classifies the error */
module hsiaoEccCor import hsiaoEccPkg::*; (
  input  eccWord_u             in,
  output eccWord_u             out,
  output logic [ProtWidth-1:0] syndrome,
  output eccErr_s              err
);

  // Odd syndrome weight points to one flipped bit
  logic singleError;

  // Syndrome bit r rechecks row r over the whole codeword
  // With identity check columns this equals stored versus recomputed check bit
  always_comb begin
    for (int r = 0; r < ProtWidth; r++) begin
      syndrome[r] = ^(in.bits & HsiaoCodes[r]);
    end
  end

  // Flip the one bit whose column pattern matches the syndrome
  // A zero syndrome matches no column, so a clean word passes unchanged
  always_comb begin
    for (int i = 0; i < TotalWidth; i++) begin
      out.bits[i] = in.bits[i] ^ (syndrome == CorrCodes[i]);
    end
  end

  // All columns have odd weight, so one error gives an odd syndrome
  // and two errors give a nonzero even one
  assign singleError = ^syndrome;

  assign err.corrected     = singleError;
  assign err.uncorrectable = ~singleError & (|syndrome);

endmodule

// File: design/hsiaoEccEnc.sv
/* Hsiao SECDED encoder
   Builds the codeword for write data and applies the error injection mask */
module hsiaoEccEnc import hsiaoEccPkg::*; (
  input  logic [DataWidth-1:0]  data,
  input  logic [TotalWidth-1:0] injMask,
  output eccWord_u              word
);

  // Codeword before any injected flips
  eccWord_u clean;

  always_comb begin
    clean.fields.data = data;
    // Each check bit is the parity of the data bits in its matrix row
    for (int r = 0; r < ProtWidth; r++) begin
      clean.fields.prot[r] = ^(data & HsiaoCodes[r][DataWidth-1:0]);
    end
  end

  // The mask may hit data and check bits alike
  // A zero mask passes the clean codeword through
  assign word.bits = clean.bits ^ injMask;

endmodule

// File: design/hsiaoEccPkg.sv
/* Hsiao SECDED package for the ECC memory
   Widths, codeword and bus types, and the constant parity-check matrix */
package hsiaoEccPkg;

  // Payload and check widths, 7 check bits being the minimum for SECDED on 32 bits
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned ProtWidth  = 7;
  localparam int unsigned TotalWidth = DataWidth + ProtWidth;

  // Array geometry
  localparam int unsigned AddrWidth = 6;
  localparam int unsigned Depth     = 2 ** AddrWidth;

  // Error event counters saturate at all ones
  localparam int unsigned CountWidth = 16;

  // Check field sits above the data field in the codeword
  typedef struct packed {
    logic [ProtWidth-1:0] prot;
    logic [DataWidth-1:0] data;
  } eccWordFields_s;

  // The matrix sees a flat vector while the datapath sees data and check fields
  typedef union packed {
    logic [TotalWidth-1:0] bits;
    eccWordFields_s        fields;
  } eccWord_u;

  // Same bit order as the usual two-bit status, correction in bit 0
  typedef struct packed {
    logic uncorrectable;
    logic corrected;
  } eccErr_s;

  // One write into the codeword array
  typedef struct packed {
    logic                 en;
    logic [AddrWidth-1:0] addr;
    eccWord_u             word;
  } eccWrReq_s;

  // One read result, the address travels along for write-back
  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
    eccWord_u             word;
  } eccRdRsp_s;

  // One row per check bit, one column per codeword bit
  typedef logic [ProtWidth-1:0][TotalWidth-1:0] hsiaoMatrix_t;

  // One syndrome pattern per codeword bit
  typedef logic [TotalWidth-1:0][ProtWidth-1:0] corrMatrix_t;

  // Data columns take odd-weight patterns of weight three or more in increasing
  // numeric order, check columns form the identity
  function automatic hsiaoMatrix_t buildHsiaoMatrix();
    hsiaoMatrix_t         m;
    logic [ProtWidth-1:0] pat;
    int                   col;
    int                   weight;
    m   = '0;
    col = 0;
    for (int v = 1; v < (1 << ProtWidth); v++) begin
      pat    = ProtWidth'(v);
      weight = $countones(pat);
      if ((col < DataWidth) && (weight >= 3) && (weight % 2 == 1)) begin
        for (int r = 0; r < ProtWidth; r++) begin
          m[r][col] = pat[r];
        end
        col++;
      end
    end
    // Each check bit covers only itself among the check columns
    for (int r = 0; r < ProtWidth; r++) begin
      m[r][DataWidth+r] = 1'b1;
    end
    return m;
  endfunction

  // Column view of the matrix, used to match a syndrome to a bit position
  function automatic corrMatrix_t transposeMatrix(hsiaoMatrix_t m);
    corrMatrix_t c;
    for (int col = 0; col < TotalWidth; col++) begin
      for (int r = 0; r < ProtWidth; r++) begin
        c[col][r] = m[r][col];
      end
    end
    return c;
  endfunction

  localparam hsiaoMatrix_t HsiaoCodes = buildHsiaoMatrix();
  localparam corrMatrix_t  CorrCodes  = transposeMatrix(HsiaoCodes);

endpackage

// File: eccMem.f
design/hsiaoEccPkg.sv
design/hsiaoEccEnc.sv
design/hsiaoEccCor.sv
design/eccArray.sv
design/eccScrubber.sv
design/eccMem.sv
sim/eccMemTb.sv

// File: sim/eccMemTb.sv
/* Testbench for the ECC memory
   Directed tests for clean reads, correction, scrubbing, detection and write-back */
module eccMemTb import hsiaoEccPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClockPeriod = 20;
  localparam int ResetCycles = 16;
  // Five times the length of about 500 operations of 4 cycles each plus reset
  localparam int WatchdogNs  = 5 * (500 * 4 + ResetCycles) * ClockPeriod;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  wrEn;
  logic [AddrWidth-1:0]  wrAddr;
  logic [DataWidth-1:0]  wrData;
  logic [TotalWidth-1:0] injMask;
  logic                  rdEn;
  logic [AddrWidth-1:0]  rdAddr;
  logic                  rdValid;
  logic [DataWidth-1:0]  rdData;
  eccErr_s               rdErr;
  logic [CountWidth-1:0] corrCount;
  logic [CountWidth-1:0] uncorrCount;

  int          valueErrors    = 0;
  int          protocolErrors = 0;
  int          cycle          = 0;
  int          corrTally      = 0;
  int          uncorrTally    = 0;
  string       testName       = "reset";
  logic [31:0] lfsrState      = 32'd67;

  // Outstanding reads in issue order with the cycle their result is due
  int                   dueQ[$];
  logic [DataWidth-1:0] dataQ[$];
  eccErr_s              errQ[$];

  eccMem eccMem_i (
    .clk         (clk),
    .rst         (rst),
    .wrEn        (wrEn),
    .wrAddr      (wrAddr),
    .wrData      (wrData),
    .injMask     (injMask),
    .rdEn        (rdEn),
    .rdAddr      (rdAddr),
    .rdValid     (rdValid),
    .rdData      (rdData),
    .rdErr       (rdErr),
    .corrCount   (corrCount),
    .uncorrCount (uncorrCount)
  );

  always #(ClockPeriod / 2) clk = ~clk;

  initial begin
    #(WatchdogNs);
    $display("ERROR watchdog: run still going after %0d ns in %s", WatchdogNs, testName);
    $display("SIMULATION FAILED");
    $finish;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] randomBits(int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // Status follows from how many codeword bits were flipped on the way in
  function automatic eccErr_s expectedStatus(logic [TotalWidth-1:0] mask);
    eccErr_s status;
    status.corrected     = ($countones(mask) == 1);
    status.uncorrectable = ($countones(mask) == 2);
    return status;
  endfunction

  task automatic reportMismatch(string what, logic [63:0] expected, logic [63:0] actual);
    $display("ERROR %s: %s expected %0h actual %0h", testName, what, expected, actual);
    valueErrors++;
  endtask

  task automatic popRead();
    void'(dueQ.pop_front());
    void'(dataQ.pop_front());
    void'(errQ.pop_front());
  endtask

  // Samples one time unit after each edge and so ahead of the stimulus
  always @(posedge clk) begin
    cycle++;
    #1;
    if (rdValid === 1'b1) begin
      if (dueQ.size() == 0 || dueQ[0] != cycle) begin
        $display("ERROR %s: rdValid came in cycle %0d with no read due", testName, cycle);
        protocolErrors++;
      end else begin
        // Data of a detected double error means nothing
        if (!errQ[0].uncorrectable && rdData !== dataQ[0]) begin
          reportMismatch("rdData", dataQ[0], rdData);
        end
        if (rdErr !== errQ[0]) begin
          reportMismatch("rdErr", errQ[0], rdErr);
        end
        popRead();
      end
    end else if (dueQ.size() != 0 && dueQ[0] == cycle) begin
      $display("ERROR %s: rdValid missing two cycles after rdEn", testName);
      protocolErrors++;
      popRead();
    end
  end

  // Moves to just after the next edge and drops both strobes
  task automatic tick();
    @(posedge clk);
    #2;
    wrEn = 1'b0;
    rdEn = 1'b0;
  endtask

  task automatic startWrite(logic [AddrWidth-1:0] addr, logic [DataWidth-1:0] data,
                            logic [TotalWidth-1:0] mask);
    wrEn    = 1'b1;
    wrAddr  = addr;
    wrData  = data;
    injMask = mask;
  endtask

  // The mask given is the one the word was written with
  task automatic startRead(logic [AddrWidth-1:0] addr, logic [DataWidth-1:0] data,
                           logic [TotalWidth-1:0] mask);
    rdEn   = 1'b1;
    rdAddr = addr;
    dueQ.push_back(cycle + 2);
    dataQ.push_back(data);
    errQ.push_back(expectedStatus(mask));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (dueQ.size() != 0 && waited < 8) begin
      tick();
      waited++;
    end
  endtask

  task automatic checkCounters();
    if (corrCount !== CountWidth'(corrTally)) begin
      reportMismatch("corrCount", corrTally, corrCount);
    end
    if (uncorrCount !== CountWidth'(uncorrTally)) begin
      reportMismatch("uncorrCount", uncorrTally, uncorrCount);
    end
  endtask

  task automatic cleanRoundTrip();
    logic [DataWidth-1:0] words [Depth];
    testName = "cleanRoundTrip";
    for (int a = 0; a < Depth; a++) begin
      words[a] = randomBits(DataWidth);
      startWrite(AddrWidth'(a), words[a], '0);
      tick();
    end
    // Back to back reads keep two results in flight
    for (int a = 0; a < Depth; a++) begin
      startRead(AddrWidth'(a), words[a], '0);
      tick();
    end
    drain();
    startRead(AddrWidth'(9), words[9], '0);
    tick();
    drain();
    checkCounters();
  endtask

  task automatic singleErrorCorrection();
    logic [DataWidth-1:0]  data;
    logic [TotalWidth-1:0] mask;
    testName = "singleErrorCorrection";
    for (int pos = 0; pos < TotalWidth; pos++) begin
      data = randomBits(DataWidth);
      mask = TotalWidth'(1) << pos;
      startWrite(AddrWidth'(pos), data, mask);
      tick();
      startRead(AddrWidth'(pos), data, mask);
      tick();
      drain();
      corrTally++;
      checkCounters();
    end
  endtask

  task automatic scrubOnRead();
    logic [AddrWidth-1:0]  addr;
    logic [DataWidth-1:0]  data;
    logic [TotalWidth-1:0] mask;
    testName = "scrubOnRead";
    for (int n = 0; n < 4; n++) begin
      addr = AddrWidth'(randomBits(AddrWidth));
      data = randomBits(DataWidth);
      mask = TotalWidth'(1) << (int'(randomBits(6)) % TotalWidth);
      startWrite(addr, data, mask);
      tick();
      startRead(addr, data, mask);
      tick();
      drain();
      corrTally++;
      // Two idle cycles let the repaired word reach the array
      tick();
      tick();
      startRead(addr, data, '0);
      tick();
      drain();
      checkCounters();
    end
  endtask

  task automatic doubleErrorDetection();
    logic [AddrWidth-1:0]  addr;
    logic [DataWidth-1:0]  data;
    logic [TotalWidth-1:0] mask;
    int                    posA;
    int                    posB;
    testName = "doubleErrorDetection";
    for (int n = 0; n < 8; n++) begin
      addr = AddrWidth'(randomBits(AddrWidth));
      data = randomBits(DataWidth);
      posA = int'(randomBits(6)) % TotalWidth;
      posB = (posA + 1 + int'(randomBits(6)) % (TotalWidth - 1)) % TotalWidth;
      mask = (TotalWidth'(1) << posA) | (TotalWidth'(1) << posB);
      startWrite(addr, data, mask);
      tick();
      startRead(addr, data, mask);
      tick();
      tick();
      tick();
      // A second read of the same word must still report the double error
      startRead(addr, data, mask);
      tick();
      drain();
      uncorrTally += 2;
      checkCounters();
    end
  endtask

  // External writes hold the bus while a corrected read completes, and in
  // the cancel case one of them rewrites the held address with new data
  task automatic backPressure(bit cancel);
    logic [AddrWidth-1:0]  addr;
    logic [DataWidth-1:0]  data;
    logic [DataWidth-1:0]  newData;
    logic [TotalWidth-1:0] mask;
    testName = cancel ? "writeBackCancelled" : "writeBackUnderBackPressure";
    addr    = AddrWidth'(randomBits(AddrWidth));
    data    = randomBits(DataWidth);
    newData = randomBits(DataWidth);
    mask    = TotalWidth'(1) << (int'(randomBits(6)) % TotalWidth);
    startWrite(addr, data, mask);
    tick();
    for (int i = 0; i < 6; i++) begin
      if (cancel && i == 4) begin
        startWrite(addr, newData, '0);
      end else begin
        startWrite(addr ^ AddrWidth'(i + 1), randomBits(DataWidth), '0);
      end
      if (i == 0) begin
        startRead(addr, data, mask);
      end
      tick();
    end
    corrTally++;
    tick();
    tick();
    startRead(addr, cancel ? newData : data, '0);
    tick();
    drain();
    checkCounters();
  endtask

  initial begin
    rst     = 1'b1;
    wrEn    = 1'b0;
    wrAddr  = '0;
    wrData  = '0;
    injMask = '0;
    rdEn    = 1'b0;
    rdAddr  = '0;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rst = 1'b0;
    checkCounters();
    cleanRoundTrip();
    singleErrorCorrection();
    scrubOnRead();
    doubleErrorDetection();
    backPressure(1'b0);
    backPressure(1'b1);
    tick();
    drain();
    $display("Errors: %0d value mismatches, %0d protocol failures",
             valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
